/* source/fpu_pkg.sv */
package fpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  funct5_t;
    typedef logic [2:0]  rm_t;
    typedef logic [3:0]  op_t;
    typedef logic [2:0]  stall_t;

    localparam int BIAS = 127;  // Single-precision exponent bias.

    // ~~~~~~~~~~~~~~~~~~~~
    // funct5 codes.
    localparam funct5_t F_ADD  = 5'b00000;
    localparam funct5_t F_SUB  = 5'b00001;
    localparam funct5_t F_MUL  = 5'b00010;
    localparam funct5_t F_SGNJ = 5'b00100;
    localparam funct5_t F_FTOI = 5'b11000;
    localparam funct5_t F_CMP  = 5'b10100;
    localparam funct5_t F_ITOF = 5'b11010;

    // ~~~~~~~~~~~~~~~~~~~~
    // Operation select.
    localparam op_t OP_ADD   = 4'd0;  // Subtract too.
    localparam op_t OP_MUL   = 4'd1;
    localparam op_t OP_FTOI  = 4'd2;
    localparam op_t OP_ITOF  = 4'd3;
    localparam op_t OP_SGNJ  = 4'd4;
    localparam op_t OP_SGNJN = 4'd5;
    localparam op_t OP_SGNJX = 4'd6;
    localparam op_t OP_FEQ   = 4'd7;
    localparam op_t OP_FLT   = 4'd8;
    localparam op_t OP_FLE   = 4'd9;
    localparam op_t OP_NONE  = 4'd15;

    // Stall counts, pipeline depth minus one.
    localparam stall_t S_ADD  = 3'd1;
    localparam stall_t S_MUL  = 3'd1;
    localparam stall_t S_ITOF = 3'd0;

    // Leading zeros of a word, 32 for zero.
    function automatic logic [5:0] lzc(input word_t v);
        logic [5:0] n;
        n = 6'd32;
        for (int i = 0; i < 32; i++) begin
            if (v[i]) begin
                n = 6'(31 - i);
            end
        end
        return n;
    endfunction

    // Round to nearest even on guard and sticky, then pack.
    function automatic word_t round_pack(
        input logic              sign,
        input logic signed [9:0] exp,
        input logic [23:0]       mant,
        input logic              guard,
        input logic              sticky
    );
        logic [24:0]       mant_r;
        logic signed [9:0] exp_r;
        logic [22:0]       frac;
        word_t             w;
        mant_r = {1'b0, mant} + {24'd0, guard & (sticky | mant[0])};
        if (mant_r[24]) begin
            frac  = mant_r[23:1];  // Carry out of rounding.
            exp_r = exp + 10'sd1;
        end else begin
            frac  = mant_r[22:0];
            exp_r = exp;
        end
        if (exp_r <= 0) begin
            w = {sign, 31'd0};  // Underflow goes to signed zero.
        end else begin
            w = {sign, exp_r[7:0], frac};
        end
        return w;
    endfunction

endpackage

/* source/fpu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_decode (
    input  fpu_pkg::funct5_t funct5,
    input  fpu_pkg::rm_t     rm,
    output fpu_pkg::op_t     op,
    output logic             sub,
    output fpu_pkg::stall_t  stall,
    output logic             no_stall
);

    always_comb begin
        op       = fpu_pkg::OP_NONE;
        sub      = 1'b0;
        stall    = '0;
        no_stall = 1'b0;
        case (funct5)
            fpu_pkg::F_ADD: begin
                op    = fpu_pkg::OP_ADD;
                stall = fpu_pkg::S_ADD;
            end
            fpu_pkg::F_SUB: begin
                op    = fpu_pkg::OP_ADD;
                sub   = 1'b1;
                stall = fpu_pkg::S_ADD;
            end
            fpu_pkg::F_MUL: begin
                op    = fpu_pkg::OP_MUL;
                stall = fpu_pkg::S_MUL;
            end
            fpu_pkg::F_ITOF: begin
                op    = fpu_pkg::OP_ITOF;
                stall = fpu_pkg::S_ITOF;
            end
            fpu_pkg::F_FTOI: begin
                op       = fpu_pkg::OP_FTOI;
                no_stall = 1'b1;
            end
            fpu_pkg::F_SGNJ: begin
                no_stall = 1'b1;
                case (rm)
                    3'b000:  op = fpu_pkg::OP_SGNJ;
                    3'b001:  op = fpu_pkg::OP_SGNJN;
                    3'b010:  op = fpu_pkg::OP_SGNJX;
                    default: op = fpu_pkg::OP_NONE;
                endcase
            end
            fpu_pkg::F_CMP: begin
                no_stall = 1'b1;
                case (rm)
                    3'b010:  op = fpu_pkg::OP_FEQ;
                    3'b001:  op = fpu_pkg::OP_FLT;
                    3'b000:  op = fpu_pkg::OP_FLE;
                    default: op = fpu_pkg::OP_NONE;
                endcase
            end
            default: op = fpu_pkg::OP_NONE;
        endcase
    end

endmodule

`default_nettype wire

/* source/fpu_addsub.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_addsub (
    input  logic           clk,
    input  logic           rstn,
    input  fpu_pkg::word_t x,
    input  fpu_pkg::word_t y,
    input  logic           sub,
    output fpu_pkg::word_t add_res
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Stage one: unpack, order and align.
    logic [7:0]  xe, ye, big_e, small_e, diff;
    logic [23:0] xm, ym, big_m, small_m;
    logic        ys, x_big, big_s, small_s;
    logic [47:0] shifted;

    logic        s1_sign;
    logic        s1_eff_sub;
    logic [7:0]  s1_exp;
    logic [26:0] s1_big;     // Mantissa with guard, round and sticky.
    logic [26:0] s1_small;

    always_comb begin
        xe      = x[30:23];
        ye      = y[30:23];
        xm      = (xe == 8'd0) ? 24'd0 : {1'b1, x[22:0]};  // Subnormals flush to zero.
        ym      = (ye == 8'd0) ? 24'd0 : {1'b1, y[22:0]};
        ys      = y[31] ^ sub;
        x_big   = {xe, xm} >= {ye, ym};
        big_s   = x_big ? x[31] : ys;
        small_s = x_big ? ys : x[31];
        big_e   = x_big ? xe : ye;
        small_e = x_big ? ye : xe;
        big_m   = x_big ? xm : ym;
        small_m = x_big ? ym : xm;
        diff    = big_e - small_e;
        shifted = {small_m, 24'd0} >> diff;
    end

    always_ff @(posedge clk) begin
        s1_sign    <= big_s;
        s1_eff_sub <= big_s ^ small_s;
        s1_exp     <= big_e;
        s1_big     <= {big_m, 3'b000};
        s1_small   <= {shifted[47:22], |shifted[21:0]};  // Sticky collects the shifted-out bits.
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stage two: add, normalize and round.
    logic [27:0]       sum;
    logic [5:0]        lz;
    logic [26:0]       norm;
    logic signed [9:0] exp_n;
    fpu_pkg::word_t    add_next;

    always_comb begin
        if (s1_eff_sub) begin
            sum = {1'b0, s1_big} - {1'b0, s1_small};  // Never negative, big is ordered first.
        end else begin
            sum = {1'b0, s1_big} + {1'b0, s1_small};
        end
        lz = fpu_pkg::lzc({sum[26:0], 5'b11111});
        if (sum[27]) begin
            norm  = {sum[27:2], sum[1] | sum[0]};
            exp_n = {2'b00, s1_exp} + 10'd1;
        end else begin
            norm  = sum[26:0] << lz;
            exp_n = {2'b00, s1_exp} - {4'd0, lz};
        end
        if (sum == 28'd0) begin
            add_next = '0;  // Exact zero is positive.
        end else begin
            add_next = fpu_pkg::round_pack(s1_sign, exp_n, norm[26:3], norm[2],
                                           norm[1] | norm[0]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            add_res <= '0;
        end else begin
            add_res <= add_next;
        end
    end

endmodule

`default_nettype wire

/* source/fpu_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_mul (
    input  logic           clk,
    input  logic           rstn,
    input  fpu_pkg::word_t x,
    input  fpu_pkg::word_t y,
    output fpu_pkg::word_t mul_res
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Stage one: mantissa product.
    logic [7:0]        xe, ye;
    logic [47:0]       s1_prod;
    logic signed [9:0] s1_exp;
    logic              s1_sign;
    logic              s1_zero;

    assign xe = x[30:23];
    assign ye = y[30:23];

    always_ff @(posedge clk) begin
        s1_prod <= {1'b1, x[22:0]} * {1'b1, y[22:0]};
        s1_exp  <= {2'b00, xe} + {2'b00, ye} - 10'(fpu_pkg::BIAS);
        s1_sign <= x[31] ^ y[31];
        s1_zero <= (xe == 8'd0) || (ye == 8'd0);  // Subnormals count as zero.
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Stage two: normalize by one and round.
    logic [23:0]       mant;
    logic              guard, sticky;
    logic signed [9:0] exp_n;
    fpu_pkg::word_t    mul_next;

    always_comb begin
        if (s1_prod[47]) begin
            mant   = s1_prod[47:24];
            guard  = s1_prod[23];
            sticky = |s1_prod[22:0];
            exp_n  = s1_exp + 10'sd1;
        end else begin
            mant   = s1_prod[46:23];
            guard  = s1_prod[22];
            sticky = |s1_prod[21:0];
            exp_n  = s1_exp;
        end
        if (s1_zero) begin
            mul_next = {s1_sign, 31'd0};
        end else begin
            mul_next = fpu_pkg::round_pack(s1_sign, exp_n, mant, guard, sticky);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mul_res <= '0;
        end else begin
            mul_res <= mul_next;
        end
    end

endmodule

`default_nettype wire

/* source/fpu_convert.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_convert (
    input  logic           clk,
    input  logic           rstn,
    input  fpu_pkg::word_t x,
    output fpu_pkg::word_t ftoi_res,
    output fpu_pkg::word_t itof_res
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Float to integer, truncating.
    logic [7:0]  fe;
    logic [7:0]  fshift;
    logic [31:0] fmag;

    always_comb begin
        fe     = x[30:23];
        fshift = 8'(fpu_pkg::BIAS + 31) - fe;
        fmag   = {1'b1, x[22:0], 8'd0} >> fshift;
        if (fe < 8'(fpu_pkg::BIAS)) begin
            ftoi_res = '0;  // Magnitude below one.
        end else if (fe >= 8'(fpu_pkg::BIAS + 31)) begin
            ftoi_res = x[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end else begin
            ftoi_res = x[31] ? -fmag : fmag;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Integer to float, one register.
    logic [31:0]       imag;
    logic [31:0]       inorm;
    logic [5:0]        ilz;
    logic signed [9:0] iexp;
    fpu_pkg::word_t    itof_next;

    always_comb begin
        imag  = x[31] ? -x : x;
        ilz   = fpu_pkg::lzc(imag);
        inorm = imag << ilz;
        iexp  = 10'(fpu_pkg::BIAS + 31) - {4'd0, ilz};
        if (imag == 32'd0) begin
            itof_next = '0;
        end else begin
            itof_next = fpu_pkg::round_pack(x[31], iexp, inorm[31:8], inorm[7], |inorm[6:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            itof_res <= '0;
        end else begin
            itof_res <= itof_next;
        end
    end

endmodule

`default_nettype wire

/* source/fpu_sign_cmp.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_sign_cmp (
    input  fpu_pkg::word_t x,
    input  fpu_pkg::word_t y,
    input  fpu_pkg::op_t   op,
    output fpu_pkg::word_t sgnj_res,
    output fpu_pkg::word_t cmp_res
);

    logic        new_sign;
    logic [30:0] xm, ym;
    logic        both_zero, eq, lt;

    always_comb begin
        case (op)
            fpu_pkg::OP_SGNJN: new_sign = ~y[31];
            fpu_pkg::OP_SGNJX: new_sign = x[31] ^ y[31];
            default:           new_sign = y[31];
        endcase
        sgnj_res = {new_sign, x[30:0]};
    end

    // Magnitudes with subnormals flushed, so both zeros compare equal.
    always_comb begin
        xm        = (x[30:23] == 8'd0) ? 31'd0 : x[30:0];
        ym        = (y[30:23] == 8'd0) ? 31'd0 : y[30:0];
        both_zero = (xm == 31'd0) && (ym == 31'd0);
        eq        = both_zero || ((x[31] == y[31]) && (xm == ym));
        if (both_zero) begin
            lt = 1'b0;
        end else if (x[31] != y[31]) begin
            lt = x[31];  // Negative x is the smaller.
        end else if (x[31]) begin
            lt = xm > ym;
        end else begin
            lt = xm < ym;
        end
        case (op)
            fpu_pkg::OP_FEQ: cmp_res = {31'd0, eq};
            fpu_pkg::OP_FLT: cmp_res = {31'd0, lt};
            fpu_pkg::OP_FLE: cmp_res = {31'd0, lt | eq};
            default:         cmp_res = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/fpu_result.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_result (
    input  logic             clk,
    input  logic             rstn,
    input  fpu_pkg::word_t   x,
    input  fpu_pkg::word_t   y,
    input  fpu_pkg::funct5_t funct5,
    input  fpu_pkg::rm_t     rm,
    input  fpu_pkg::op_t     op,
    input  fpu_pkg::stall_t  stall,
    input  logic             no_stall,
    input  fpu_pkg::word_t   add_res,
    input  fpu_pkg::word_t   mul_res,
    input  fpu_pkg::word_t   ftoi_res,
    input  fpu_pkg::word_t   itof_res,
    input  fpu_pkg::word_t   sgnj_res,
    input  fpu_pkg::word_t   cmp_res,
    output fpu_pkg::word_t   res,
    output logic             valid
);

    fpu_pkg::word_t   pre_x, pre_y;
    fpu_pkg::funct5_t pre_funct5;
    fpu_pkg::rm_t     pre_rm;
    fpu_pkg::stall_t  counter;
    logic             input_changed;

    assign input_changed = (x != pre_x) || (y != pre_y) ||
                           (funct5 != pre_funct5) || (rm != pre_rm);
    assign valid = no_stall || (!input_changed && (counter == '0));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pre_x      <= '0;
            pre_y      <= '0;
            pre_funct5 <= '0;
            pre_rm     <= '0;
            counter    <= '0;
        end else begin
            pre_x      <= x;
            pre_y      <= y;
            pre_funct5 <= funct5;
            pre_rm     <= rm;
            if (input_changed) begin
                counter <= stall;  // A new operation restarts the wait.
            end else if (counter != '0) begin
                counter <= counter - 3'd1;
            end
        end
    end

    always_comb begin
        case (op)
            fpu_pkg::OP_ADD:   res = add_res;
            fpu_pkg::OP_MUL:   res = mul_res;
            fpu_pkg::OP_FTOI:  res = ftoi_res;
            fpu_pkg::OP_ITOF:  res = itof_res;
            fpu_pkg::OP_SGNJ,
            fpu_pkg::OP_SGNJN,
            fpu_pkg::OP_SGNJX: res = sgnj_res;
            fpu_pkg::OP_FEQ,
            fpu_pkg::OP_FLT,
            fpu_pkg::OP_FLE:   res = cmp_res;
            default:           res = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/fpu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_pipe (
    input  logic             clk,
    input  logic             rstn,
    input  fpu_pkg::word_t   x,
    input  fpu_pkg::word_t   y,
    input  fpu_pkg::funct5_t funct5,
    input  fpu_pkg::rm_t     rm,
    output fpu_pkg::word_t   res,
    output logic             valid
);

    fpu_pkg::op_t    op;
    logic            sub;
    fpu_pkg::stall_t stall;
    logic            no_stall;
    fpu_pkg::word_t  add_res, mul_res, ftoi_res, itof_res, sgnj_res, cmp_res;

    fpu_decode u_decode (
        .funct5   (funct5),
        .rm       (rm),
        .op       (op),
        .sub      (sub),
        .stall    (stall),
        .no_stall (no_stall)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Execute units, free running.
    fpu_addsub u_addsub (
        .clk     (clk),
        .rstn    (rstn),
        .x       (x),
        .y       (y),
        .sub     (sub),
        .add_res (add_res)
    );

    fpu_mul u_mul (
        .clk     (clk),
        .rstn    (rstn),
        .x       (x),
        .y       (y),
        .mul_res (mul_res)
    );

    fpu_convert u_convert (
        .clk      (clk),
        .rstn     (rstn),
        .x        (x),
        .ftoi_res (ftoi_res),
        .itof_res (itof_res)
    );

    fpu_sign_cmp u_sign_cmp (
        .x        (x),
        .y        (y),
        .op       (op),
        .sgnj_res (sgnj_res),
        .cmp_res  (cmp_res)
    );

    fpu_result u_result (
        .clk      (clk),
        .rstn     (rstn),
        .x        (x),
        .y        (y),
        .funct5   (funct5),
        .rm       (rm),
        .op       (op),
        .stall    (stall),
        .no_stall (no_stall),
        .add_res  (add_res),
        .mul_res  (mul_res),
        .ftoi_res (ftoi_res),
        .itof_res (itof_res),
        .sgnj_res (sgnj_res),
        .cmp_res  (cmp_res),
        .res      (res),
        .valid    (valid)
    );

endmodule

`default_nettype wire

/* tests/fpu_pipe_props.sv */
`timescale 1ns/1ps

module fpu_pipe_props (
    input logic            clk,
    input logic            rstn,
    input logic            valid,
    input logic            no_stall,
    input logic            input_changed,
    input fpu_pkg::stall_t stall,
    input fpu_pkg::stall_t counter
);

    no_stall_valid: assert property (@(posedge clk) disable iff (!rstn)
        no_stall |-> valid)
        else $error("valid low while no_stall is high");

    // One stall cycle after the change edge.
    stall_low: assert property (@(posedge clk) disable iff (!rstn)
        (!input_changed && $past(input_changed) && !$past(no_stall) && $past(stall) == 3'd1)
        |-> !valid)
        else $error("valid high one cycle after a change with stall 1");

    stall_high: assert property (@(posedge clk) disable iff (!rstn)
        (!input_changed && !$past(input_changed) && $past(input_changed, 2) &&
         !$past(no_stall, 2) && $past(stall, 2) == 3'd1)
        |-> valid)
        else $error("valid low two cycles after a change with held inputs");

    counter_bound: assert property (@(posedge clk) disable iff (!rstn)
        counter <= fpu_pkg::S_ADD)
        else $error("stall counter above the largest stall count");

endmodule

bind fpu_result fpu_pipe_props u_props (
    .clk           (clk),
    .rstn          (rstn),
    .valid         (valid),
    .no_stall      (no_stall),
    .input_changed (input_changed),
    .stall         (stall),
    .counter       (counter)
);

/* tests/fpu_pipe_tb.sv */
`timescale 1ns/1ps

module fpu_pipe_tb;

    localparam int MAX_CYCLES = 3000;  // About 200 operations of up to 3 cycles, plus margin.

    logic             clk;
    logic             rstn;
    fpu_pkg::word_t   x;
    fpu_pkg::word_t   y;
    fpu_pkg::funct5_t funct5;
    fpu_pkg::rm_t     rm;
    fpu_pkg::word_t   res;
    logic             valid;

    fpu_pkg::word_t   exp_res;  // Expected res for the inputs now applied.
    logic             chk_en;
    int               errors;
    int               checks;
    int               cycles;

    fpu_pipe UUT (
        .clk    (clk),
        .rstn   (rstn),
        .x      (x),
        .y      (y),
        .funct5 (funct5),
        .rm     (rm),
        .res    (res),
        .valid  (valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    res_check: assert property (@(posedge clk) disable iff (!rstn)
        (chk_en && valid) |-> (res == exp_res))
        else begin
            errors++;
            $display("CHECK FAILED time %0t res expected %h actual %h",
                     $time, $sampled(exp_res), $sampled(res));
        end

    // ~~~~~~~~~~~~~~~~~~~~
    // IEEE single words built from the fields of exact doubles.
    function automatic fpu_pkg::word_t to_word(input real v);
        logic [63:0] b;
        logic [10:0] e;
        b = $realtobits(v);
        e = b[62:52] - 11'd896;  // Rebias 1023 to 127.
        if (v == 0.0) begin
            return '0;
        end
        return {b[63], e[7:0], b[51:29]};
    endfunction

    function automatic real to_real(input fpu_pkg::word_t w);
        logic [10:0] e;
        e = {3'b000, w[30:23]} + 11'd896;
        if (w[30:23] == 8'd0) begin
            return 0.0;  // Subnormals count as zero.
        end
        return $bitstoreal({w[31], e, w[22:0], 29'd0});
    endfunction

    function automatic fpu_pkg::word_t rand_float();
        fpu_pkg::word_t w;
        w = $urandom;
        w[30:23] = 8'($urandom_range(254, 1));  // Normal values only.
        return w;
    endfunction

    function automatic fpu_pkg::word_t trunc_int(input real v);
        fpu_pkg::word_t w;
        if (v >= 2147483648.0) begin
            w = 32'h7fff_ffff;
        end else if (v <= -2147483648.0) begin
            w = 32'h8000_0000;
        end else begin
            w = $rtoi(v);  // Truncates toward zero.
        end
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Operation drivers.
    task automatic apply_op(input fpu_pkg::word_t a, input fpu_pkg::word_t b,
                            input fpu_pkg::funct5_t f, input fpu_pkg::rm_t r,
                            input fpu_pkg::word_t want);
        @(posedge clk);
        #2;
        x       = a;
        y       = b;
        funct5  = f;
        rm      = r;
        exp_res = want;
        chk_en  = 1'b1;
    endtask

    task automatic finish_op(input int lat);
        int waited;
        waited = 0;
        #1;
        while (!valid) begin
            @(posedge clk);
            #2;
            waited++;
        end
        checks++;
        assert (res == exp_res) else begin
            errors++;
            $display("CHECK FAILED time %0t res expected %h actual %h", $time, exp_res, res);
        end
        assert (waited == lat) else begin
            errors++;
            $display("CHECK FAILED time %0t valid cycles expected %0d actual %0d",
                     $time, lat, waited);
        end
    endtask

    task automatic run_op(input fpu_pkg::word_t a, input fpu_pkg::word_t b,
                          input fpu_pkg::funct5_t f, input fpu_pkg::rm_t r,
                          input fpu_pkg::word_t want, input int lat);
        apply_op(a, b, f, r, want);
        finish_op(lat);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %s finished with %0d errors", name, errors - errs_before);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Tests.
    task automatic sign_inject_test();
        fpu_pkg::word_t a;
        fpu_pkg::word_t b;
        for (int i = 0; i < 40; i++) begin
            a = $urandom;
            b = $urandom;
            run_op(a, b, fpu_pkg::F_SGNJ, 3'b000, {b[31], a[30:0]}, 0);
            run_op(a, b, fpu_pkg::F_SGNJ, 3'b001, {~b[31], a[30:0]}, 0);
            run_op(a, b, fpu_pkg::F_SGNJ, 3'b010, {a[31] ^ b[31], a[30:0]}, 0);
        end
    endtask

    task automatic compare_pair(input fpu_pkg::word_t a, input fpu_pkg::word_t b);
        real ra;
        real rb;
        ra = to_real(a);
        rb = to_real(b);
        run_op(a, b, fpu_pkg::F_CMP, 3'b010, {31'd0, (ra == rb)}, 0);  // feq.
        run_op(a, b, fpu_pkg::F_CMP, 3'b001, {31'd0, (ra < rb)}, 0);   // flt.
        run_op(a, b, fpu_pkg::F_CMP, 3'b000, {31'd0, (ra <= rb)}, 0);  // fle.
    endtask

    task automatic compare_test();
        fpu_pkg::word_t a;
        for (int i = 0; i < 12; i++) begin
            a = rand_float();
            if (i % 4 == 3) begin
                compare_pair(a, a);
            end else begin
                compare_pair(a, rand_float());
            end
        end
        compare_pair(32'h0000_0000, 32'h8000_0000);
        compare_pair(32'h8000_0000, 32'h0000_0000);
    endtask

    task automatic convert_test();
        real            vals[6] = '{2.75, -2.75, 1.0e10, -1.0e10, 0.5, 100.5};
        fpu_pkg::word_t w;
        int             k;
        foreach (vals[i]) begin
            w = to_word(vals[i]);
            run_op(w, '0, fpu_pkg::F_FTOI, 3'b000, trunc_int(to_real(w)), 0);
        end
        for (int i = 0; i < 15; i++) begin
            k = int'($urandom_range(32'h00ff_ffff, 1));
            if (i >= 10) begin
                k = -k;
            end
            run_op(fpu_pkg::word_t'(k), '0, fpu_pkg::F_ITOF, 3'b000, to_word($itor(k)), 1);
        end
    endtask

    task automatic add_test();
        int  ka;
        int  kb;
        real ra;
        real rb;
        for (int i = 0; i < 10; i++) begin
            ka = int'($urandom_range(4000, 0)) - 2000;
            kb = int'($urandom_range(4000, 0)) - 2000;
            ra = $itor(ka) / 4.0;
            rb = $itor(kb) / 4.0;
            if (i % 2 == 1) begin
                run_op(to_word(ra), to_word(rb), fpu_pkg::F_SUB, 3'b000, to_word(ra - rb), 2);
            end else begin
                run_op(to_word(ra), to_word(rb), fpu_pkg::F_ADD, 3'b000, to_word(ra + rb), 2);
            end
        end
        run_op(to_word(1024.0), to_word(0.125), fpu_pkg::F_ADD, 3'b000, to_word(1024.125), 2);
        run_op(to_word(-6.5), to_word(-6.5), fpu_pkg::F_SUB, 3'b000, 32'h0000_0000, 2);
        run_op(to_word(0.75), to_word(-0.75), fpu_pkg::F_ADD, 3'b000, 32'h0000_0000, 2);
    endtask

    task automatic mul_test();
        int  ka;
        int  kb;
        real ra;
        real rb;
        for (int i = 0; i < 10; i++) begin
            ka = int'($urandom_range(2000, 1)) - 1000;
            kb = int'($urandom_range(2000, 1)) - 1000;
            ra = $itor(ka) / $itor(1 << $urandom_range(4, 0));
            rb = $itor(kb) / $itor(1 << $urandom_range(4, 0));
            if (ka == 0) begin
                ra = ra + 1.0;  // Zero operands are covered below.
            end
            if (kb == 0) begin
                rb = rb + 1.0;
            end
            run_op(to_word(ra), to_word(rb), fpu_pkg::F_MUL, 3'b000, to_word(ra * rb), 2);
        end
        run_op(to_word(-1.5), to_word(-2.0), fpu_pkg::F_MUL, 3'b000, to_word(3.0), 2);
        run_op(to_word(-1.5), to_word(2.0), fpu_pkg::F_MUL, 3'b000, to_word(-3.0), 2);
        run_op(32'h0000_0000, to_word(-3.0), fpu_pkg::F_MUL, 3'b000, 32'h8000_0000, 2);
        run_op(32'h8000_0000, to_word(2.5), fpu_pkg::F_MUL, 3'b000, 32'h8000_0000, 2);
        run_op(to_word(1024.0), to_word(0.000244140625), fpu_pkg::F_MUL, 3'b000,
               to_word(0.25), 2);
    endtask

    task automatic restart_test();
        real base;
        for (int i = 0; i < 3; i++) begin
            base = $itor(i) * 8.0;
            apply_op(to_word(base + 3.0), to_word(0.5), fpu_pkg::F_ADD, 3'b000,
                     to_word(base + 3.5));
            #1;
            assert (!valid) else begin
                errors++;
                $display("CHECK FAILED time %0t valid expected 0 actual %b", $time, valid);
            end
            apply_op(to_word(base + 1.25), to_word(0.5), fpu_pkg::F_SUB, 3'b000,
                     to_word(base + 0.75));
            finish_op(2);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not end within %0d clock cycles", MAX_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int errs;
        rstn    = 1'b0;
        x       = '0;
        y       = '0;
        funct5  = '0;
        rm      = '0;
        exp_res = '0;
        chk_en  = 1'b0;
        errors  = 0;
        checks  = 0;
        void'($urandom(32'h8f1a_2c05));
        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;

        errs = errors;
        sign_inject_test();
        report_test("sign injection", errs);
        errs = errors;
        compare_test();
        report_test("compare", errs);
        errs = errors;
        convert_test();
        report_test("convert", errs);
        errs = errors;
        add_test();
        report_test("add and subtract", errs);
        errs = errors;
        mul_test();
        report_test("multiply", errs);
        errs = errors;
        restart_test();
        report_test("restart on change", errs);

        @(posedge clk);
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* fpu_pipe.f */
source/fpu_pkg.sv
source/fpu_decode.sv
source/fpu_addsub.sv
source/fpu_mul.sv
source/fpu_convert.sv
source/fpu_sign_cmp.sv
source/fpu_result.sv
source/fpu_pipe.sv
tests/fpu_pipe_props.sv
tests/fpu_pipe_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fpu_pipe_tb
FILELIST  ?= fpu_pipe.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: sim clean
